// File: src.f
+incdir+design
design/cluster_periph_pkg.sv
design/periph_bus_if.sv
design/evt_ctrl_if.sv
design/periph_demux.sv
design/cluster_ctrl_unit.sv
design/cluster_timer.sv
design/event_unit_regs.sv
design/event_unit_core.sv
design/cluster_peripherals.sv
verif/tb_cluster_peripherals.sv

// File: verif/tb_cluster_peripherals.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module tb_cluster_peripherals
  import cluster_periph_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int TIMER_CMP    = 20;
  // cycles allowed for the timer event to reach core 1
  localparam int TIMER_WAIT   = 4 * TIMER_CMP;

  // cycle budget of each test
  localparam int CTRL_CYCLES  = 40;
  localparam int RESP_CYCLES  = 30;
  localparam int TIMER_CYCLES = 40 + TIMER_WAIT;
  localparam int SW_CYCLES    = 60;
  localparam int SLEEP_CYCLES = 40;
  localparam int BUDGET_CYCLES = RESET_CYCLES + CTRL_CYCLES + RESP_CYCLES +
                                 TIMER_CYCLES + SW_CYCLES + SLEEP_CYCLES;
  localparam int WATCHDOG_NS  = BUDGET_CYCLES * CLK_PERIOD * 3 / 2;

  // requester with no core bit set
  localparam per_id_t NOCORE_ID = per_id_t'(1) << `CP_NB_CORES;

  logic      clk_i;
  logic      reset_i;
  logic      req_i;
  word_t     add_i;
  logic      wen_i;
  word_t     wdata_i;
  per_id_t   id_i;
  logic      gnt_o;
  logic      r_valid_o;
  word_t     r_rdata_o;
  per_id_t   r_id_o;
  logic      en_sa_boot_i;
  logic      fetch_en_i;
  logic      eoc_o;
  core_vec_t fetch_enable_o;
  word_t     boot_addr_o;
  logic      busy_o;
  core_vec_t irq_ack_i;
  core_vec_t irq_req_o;
  core_vec_t core_clk_en_o;
  string     test_name;

  cluster_peripherals i_cluster_peripherals (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .req_i          ( req_i          ),
    .add_i          ( add_i          ),
    .wen_i          ( wen_i          ),
    .wdata_i        ( wdata_i        ),
    .id_i           ( id_i           ),
    .gnt_o          ( gnt_o          ),
    .r_valid_o      ( r_valid_o      ),
    .r_rdata_o      ( r_rdata_o      ),
    .r_id_o         ( r_id_o         ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .fetch_en_i     ( fetch_en_i     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .busy_o         ( busy_o         ),
    .irq_ack_i      ( irq_ack_i      ),
    .irq_req_o      ( irq_req_o      ),
    .core_clk_en_o  ( core_clk_en_o  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //**************************************************************************
  // compare tasks and helpers
  //**************************************************************************

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_core_vec(input string what, input core_vec_t exp,
                                input core_vec_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string what, input per_id_t exp, input per_id_t act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  function automatic word_t reg_addr(input slot_t slot, input reg_off_t off);
    word_t addr;
    addr = '0;
    addr[`CP_SLOT_LSB +: 2] = slot;
    addr[`CP_OFF_LSB +: 4]  = off;
    return addr;
  endfunction

  function automatic per_id_t core_id(input int c);
    return per_id_t'(1) << c;
  endfunction

  // all bus tasks start and end 1 ns after a rising edge
  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk_i);
    #1;
  endtask

  task automatic bus_write(input word_t addr, input per_id_t rid, input word_t data);
    req_i   = 1'b1;
    add_i   = addr;
    wen_i   = 1'b0;
    wdata_i = data;
    id_i    = rid;
    @(negedge clk_i);
    check_bit("write gnt_o", 1'b1, gnt_o);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic bus_read(input word_t addr, input per_id_t rid, output word_t data);
    req_i   = 1'b1;
    add_i   = addr;
    wen_i   = 1'b1;
    wdata_i = '0;
    id_i    = rid;
    @(negedge clk_i);
    check_bit("read gnt_o", 1'b1, gnt_o);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    // response is due in the cycle right after the grant
    check_bit("read r_valid_o", 1'b1, r_valid_o);
    check_id("read r_id_o", rid, r_id_o);
    data = r_rdata_o;
  endtask

  task automatic read_expect(input string what, input word_t addr, input per_id_t rid,
                             input word_t exp);
    word_t data;
    bus_read(addr, rid, data);
    check_word(what, exp, data);
  endtask

  task automatic pulse_ack(input core_vec_t cores);
    irq_ack_i = cores;
    idle(1);
    irq_ack_i = '0;
  endtask

  //**************************************************************************
  // directed tests
  //**************************************************************************

  task automatic test_ctrl_unit();
    word_t boot;
    word_t eoc_data;
    test_name = "ctrl_unit";
    check_bit("eoc_o after reset", 1'b0, eoc_o);
    check_core_vec("fetch_enable_o after reset", '0, fetch_enable_o);
    // en_sa_boot_i is held high through reset
    check_word("boot_addr_o after reset", `CP_BOOT_ADDR, boot_addr_o);
    boot = $urandom();
    bus_write(reg_addr(`CP_SLOT_CTRL, `CP_OFF_BOOT_ADDR), core_id(0), boot);
    check_word("boot_addr_o", boot, boot_addr_o);
    read_expect("BOOT_ADDR", reg_addr(`CP_SLOT_CTRL, `CP_OFF_BOOT_ADDR), core_id(1), boot);
    // eoc keeps bit 0 only
    eoc_data = $urandom() | 32'h1;
    bus_write(reg_addr(`CP_SLOT_CTRL, `CP_OFF_EOC), core_id(0), eoc_data);
    check_bit("eoc_o set", 1'b1, eoc_o);
    read_expect("EOC", reg_addr(`CP_SLOT_CTRL, `CP_OFF_EOC), core_id(2), 32'h1);
    bus_write(reg_addr(`CP_SLOT_CTRL, `CP_OFF_EOC), core_id(0), eoc_data & ~32'h1);
    check_bit("eoc_o clear", 1'b0, eoc_o);
    bus_write(reg_addr(`CP_SLOT_CTRL, `CP_OFF_FETCH_EN), core_id(0), 32'h5);
    check_core_vec("fetch_enable_o register", core_vec_t'(4'b0101), fetch_enable_o);
    read_expect("FETCH_EN", reg_addr(`CP_SLOT_CTRL, `CP_OFF_FETCH_EN), core_id(3), 32'h5);
    fetch_en_i = 1'b1;
    idle(1);
    check_core_vec("fetch_enable_o with fetch_en_i", '1, fetch_enable_o);
    fetch_en_i = 1'b0;
    bus_write(reg_addr(`CP_SLOT_CTRL, `CP_OFF_FETCH_EN), core_id(0), 32'h0);
    check_core_vec("fetch_enable_o cleared", '0, fetch_enable_o);
  endtask

  task automatic test_response_path();
    word_t   addr [3];
    per_id_t rid  [3];
    word_t   exp  [3];
    test_name = "response_path";
    read_expect("slot 3", reg_addr(slot_t'(3), 4'd0), NOCORE_ID, `CP_ERR_RDATA);
    read_expect("ctrl offset 7", reg_addr(`CP_SLOT_CTRL, 4'd7), core_id(0), `CP_ERR_RDATA);
    addr[0] = reg_addr(`CP_SLOT_CTRL, `CP_OFF_BOOT_ADDR);
    addr[1] = reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_CMP);
    addr[2] = reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK);
    rid[0]  = core_id(0);
    rid[1]  = core_id(1);
    rid[2]  = core_id(3);
    exp[0]  = $urandom();
    exp[1]  = $urandom();
    exp[2]  = word_t'(evt_t'($urandom()));
    for (int i = 0; i < 3; i++) begin
      bus_write(addr[i], rid[i], exp[i]);
    end
    // one request per cycle while each response lands one cycle later
    for (int i = 0; i <= 3; i++) begin
      if (i > 0) begin
        check_bit("back-to-back r_valid_o", 1'b1, r_valid_o);
        check_id("back-to-back r_id_o", rid[i-1], r_id_o);
        check_word("back-to-back r_rdata_o", exp[i-1], r_rdata_o);
      end
      if (i < 3) begin
        req_i = 1'b1;
        add_i = addr[i];
        wen_i = 1'b1;
        id_i  = rid[i];
        idle(1);
      end else begin
        req_i = 1'b0;
      end
    end
  endtask

  task automatic test_timer();
    word_t count_val;
    int    waited;
    test_name = "timer";
    bus_write(reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_CMP), core_id(0), TIMER_CMP);
    bus_write(reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_COUNT), core_id(0), 32'h0);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(1), 32'h1);
    bus_write(reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_CFG), core_id(0), 32'h1);
    check_bit("busy_o enabled", 1'b1, busy_o);
    waited = 0;
    while (!irq_req_o[1] && (waited < TIMER_WAIT)) begin
      idle(1);
      waited++;
    end
    if (!irq_req_o[1]) begin
      $display("timer event did not reach core 1 within %0d cycles", TIMER_WAIT);
      stop_on_error();
    end
    read_expect("core 1 BUFFER", reg_addr(`CP_SLOT_EU, `CP_OFF_EU_BUFFER), core_id(1), 32'h1);
    bus_write(reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_CFG), core_id(0), 32'h0);
    check_bit("busy_o disabled", 1'b0, busy_o);
    count_val = $urandom();
    bus_write(reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_COUNT), core_id(0), count_val);
    idle(5);
    read_expect("COUNT held", reg_addr(`CP_SLOT_TIMER, `CP_OFF_TIM_COUNT), core_id(0),
                count_val);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(1), 32'h0);
    pulse_ack('1);
  endtask

  task automatic test_sw_events();
    evt_t      sw;
    evt_t      clr;
    evt_t      mask [`CP_NB_CORES];
    core_vec_t exp_irq;
    test_name = "sw_events";
    sw = evt_t'($urandom()) & ~evt_t'(1);
    if (sw == '0) begin
      sw = evt_t'(8'h80);
    end
    // full, disjoint, empty and all-ones masks
    mask[0] = sw;
    mask[1] = ~sw & ~evt_t'(1);
    mask[2] = '0;
    mask[3] = '1;
    // only the full and all-ones masks overlap the events
    exp_irq = core_vec_t'(4'b1001);
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(c), word_t'(mask[c]));
    end
    check_core_vec("irq_req_o before SW_EVT", '0, irq_req_o);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_SW_EVT), core_id(0), word_t'(sw));
    check_core_vec("irq_req_o after SW_EVT", exp_irq, irq_req_o);
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      read_expect($sformatf("core %0d BUFFER", c), reg_addr(`CP_SLOT_EU, `CP_OFF_EU_BUFFER),
                  core_id(c), word_t'(sw));
    end
    pulse_ack(core_vec_t'(1));
    exp_irq[0] = 1'b0;
    check_core_vec("irq_req_o after ack", exp_irq, irq_req_o);
    read_expect("core 0 BUFFER after ack", reg_addr(`CP_SLOT_EU, `CP_OFF_EU_BUFFER),
                core_id(0), 32'h0);
    clr = sw & (~sw + 1'b1);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_BUFFER), core_id(3), word_t'(clr));
    read_expect("core 3 BUFFER after clear", reg_addr(`CP_SLOT_EU, `CP_OFF_EU_BUFFER),
                core_id(3), word_t'(sw & ~clr));
    pulse_ack('1);
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(c), 32'h0);
    end
  endtask

  task automatic test_sleep_wake();
    core_vec_t awake;
    test_name = "sleep_wake";
    awake = ~(core_vec_t'(1) << 2);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(2), 32'h10);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_SLEEP), core_id(2), 32'h0);
    check_core_vec("core_clk_en_o after SLEEP", awake, core_clk_en_o);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_SW_EVT), core_id(0), 32'h04);
    idle(2);
    check_core_vec("core_clk_en_o unmasked event", awake, core_clk_en_o);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_SW_EVT), core_id(0), 32'h10);
    check_bit("irq_req_o core 2", 1'b1, irq_req_o[2]);
    check_core_vec("core_clk_en_o before wake", awake, core_clk_en_o);
    idle(1);
    check_core_vec("core_clk_en_o after wake", '1, core_clk_en_o);
    pulse_ack('1);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_SLEEP), NOCORE_ID, 32'h0);
    idle(2);
    check_core_vec("core_clk_en_o SLEEP without core", '1, core_clk_en_o);
    bus_write(reg_addr(`CP_SLOT_EU, `CP_OFF_EU_MASK), core_id(2), 32'h0);
  endtask

  //**************************************************************************
  // run and watchdog
  //**************************************************************************

  initial begin
    int seed;
    seed = 32'h4449_0beb;
    void'($urandom(seed));
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_i        = 1'b0;
    add_i        = '0;
    wen_i        = 1'b1;
    wdata_i      = '0;
    id_i         = '0;
    en_sa_boot_i = 1'b1;
    fetch_en_i   = 1'b0;
    irq_ack_i    = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_ctrl_unit();
    test_response_path();
    test_timer();
    test_sw_events();
    test_sleep_wake();
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, a test did not finish", WATCHDOG_NS);
    stop_on_error();
  end

endmodule

// File: design/cluster_peripherals.sv
`timescale 1ns/1ps

module cluster_peripherals
  import cluster_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  // peripheral bus
  input  logic      req_i,
  input  word_t     add_i,
  input  logic      wen_i,
  input  word_t     wdata_i,
  input  per_id_t   id_i,
  output logic      gnt_o,
  output logic      r_valid_o,
  output word_t     r_rdata_o,
  output per_id_t   r_id_o,

  // boot and control
  input  logic      en_sa_boot_i,
  input  logic      fetch_en_i,
  output logic      eoc_o,
  output core_vec_t fetch_enable_o,
  output word_t     boot_addr_o,
  output logic      busy_o,

  // per-core interrupts and clock gating
  input  core_vec_t irq_ack_i,
  output core_vec_t irq_req_o,
  output core_vec_t core_clk_en_o
);

  logic timer_evt;

  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if eu_bus ();
  evt_ctrl_if   evt_ctrl ();

  //**************************************************************************
  // address decode
  //**************************************************************************

  periph_demux i_periph_demux (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .req_i     ( req_i     ),
    .add_i     ( add_i     ),
    .wen_i     ( wen_i     ),
    .wdata_i   ( wdata_i   ),
    .id_i      ( id_i      ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_rdata_o ( r_rdata_o ),
    .r_id_o    ( r_id_o    ),
    .ctrl_bus  ( ctrl_bus  ),
    .timer_bus ( timer_bus ),
    .eu_bus    ( eu_bus    )
  );

  //**************************************************************************
  // control unit and timer
  //**************************************************************************

  cluster_ctrl_unit i_cluster_ctrl_unit (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .bus            ( ctrl_bus       ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .fetch_en_i     ( fetch_en_i     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_cluster_timer (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .bus     ( timer_bus ),
    .event_o ( timer_evt ),
    .busy_o  ( busy_o    )
  );

  //**************************************************************************
  // event unit
  //**************************************************************************

  event_unit_regs i_event_unit_regs (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .bus     ( eu_bus   ),
    .ctrl    ( evt_ctrl )
  );

  event_unit_core i_event_unit_core (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .ctrl          ( evt_ctrl      ),
    .timer_evt_i   ( timer_evt     ),
    .irq_ack_i     ( irq_ack_i     ),
    .irq_req_o     ( irq_req_o     ),
    .core_clk_en_o ( core_clk_en_o )
  );

endmodule

// File: design/event_unit_core.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module event_unit_core
  import cluster_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  evt_ctrl_if.core  ctrl,
  input  logic      timer_evt_i,
  input  core_vec_t irq_ack_i,
  output core_vec_t irq_req_o,
  output core_vec_t core_clk_en_o
);

  evt_t [`CP_NB_CORES-1:0] buffer_q;
  evt_t                    evt_set;
  core_vec_t               pending;
  core_vec_t               sleep_q;

  // timer on bit 0 and software events above it, same for every core
  always_comb begin
    evt_set    = '0;
    evt_set[0] = timer_evt_i;
    if (ctrl.sw_evt_valid) begin
      evt_set[`CP_EVNT_WIDTH-1:1] = ctrl.sw_evt[`CP_EVNT_WIDTH-1:1];
    end
  end

  // new events win over clears in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buffer_q <= '0;
    end else begin
      for (int c = 0; c < `CP_NB_CORES; c++) begin
        if (irq_ack_i[c]) begin
          buffer_q[c] <= evt_set;
        end else begin
          buffer_q[c] <= (buffer_q[c] & ~ctrl.buf_clr[c]) | evt_set;
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      pending[c] = |(buffer_q[c] & ctrl.mask[c]);
    end
  end

  // a pending masked event keeps the core awake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sleep_q <= '0;
    end else begin
      sleep_q <= (sleep_q | ctrl.sleep_set) & ~pending;
    end
  end

  assign ctrl.buffer   = buffer_q;
  assign irq_req_o     = pending;
  assign core_clk_en_o = ~sleep_q;

endmodule

// File: design/event_unit_regs.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module event_unit_regs
  import cluster_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  periph_bus_if.slave bus,
  evt_ctrl_if.regs    ctrl
);

  reg_off_t                off;
  logic                    wr;
  core_vec_t               core_bits;
  core_vec_t               core_sel;
  evt_t                    wr_evt;
  evt_t [`CP_NB_CORES-1:0] mask_q;
  evt_t                    sel_mask;
  evt_t                    sel_buf;
  word_t                   rdata;
  logic                    r_valid_q;
  word_t                   r_rdata_q;
  per_id_t                 r_id_q;

  assign off     = bus.add[`CP_OFF_LSB +: 4];
  assign wr      = bus.req && !bus.wen;
  assign wr_evt  = bus.wdata[`CP_EVNT_WIDTH-1:0];
  assign bus.gnt = bus.req;

  // requesting core is the lowest set core bit, empty if none
  assign core_bits = bus.id[`CP_NB_CORES-1:0];
  assign core_sel  = core_bits & (~core_bits + 1'b1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
    end else if (wr && (off == `CP_OFF_EU_MASK)) begin
      for (int c = 0; c < `CP_NB_CORES; c++) begin
        if (core_sel[c]) begin
          mask_q[c] <= wr_evt;
        end
      end
    end
  end

  // controls to the core act on the grant edge
  always_comb begin
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      ctrl.buf_clr[c] = (wr && (off == `CP_OFF_EU_BUFFER) && core_sel[c]) ? wr_evt : '0;
    end
    ctrl.sleep_set = (wr && (off == `CP_OFF_EU_SLEEP)) ? core_sel : '0;
  end

  assign ctrl.mask         = mask_q;
  assign ctrl.sw_evt_valid = wr && (off == `CP_OFF_EU_SW_EVT);
  // bit 0 belongs to the timer
  assign ctrl.sw_evt       = wr_evt & ~evt_t'(1);

  always_comb begin
    sel_mask = '0;
    sel_buf  = '0;
    for (int c = 0; c < `CP_NB_CORES; c++) begin
      if (core_sel[c]) begin
        sel_mask = mask_q[c];
        sel_buf  = ctrl.buffer[c];
      end
    end
    case (off)
      `CP_OFF_EU_MASK:   rdata = word_t'(sel_mask);
      `CP_OFF_EU_BUFFER: rdata = word_t'(sel_buf);
      `CP_OFF_EU_SW_EVT: rdata = '0;
      `CP_OFF_EU_SLEEP:  rdata = '0;
      default:           rdata = `CP_ERR_RDATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rdata;
      r_id_q    <= bus.id;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_id    = r_id_q;

endmodule

// File: design/cluster_timer.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  periph_bus_if.slave bus,
  output logic        event_o,
  output logic        busy_o
);

  reg_off_t off;
  logic     wr;
  logic     en_q;
  word_t    count_q;
  word_t    cmp_q;
  logic     match;
  word_t    rdata;
  logic     r_valid_q;
  word_t    r_rdata_q;
  per_id_t  r_id_q;

  assign off     = bus.add[`CP_OFF_LSB +: 4];
  assign wr      = bus.req && !bus.wen;
  assign bus.gnt = bus.req;

  //**************************************************************************
  // counter and compare
  //**************************************************************************

  // match only counts while the timer runs
  assign match = en_q && (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      if (wr && (off == `CP_OFF_TIM_CFG)) begin
        en_q <= bus.wdata[0];
      end
      if (wr && (off == `CP_OFF_TIM_CMP)) begin
        cmp_q <= bus.wdata;
      end
      // a bus write to COUNT overrides counting
      if (wr && (off == `CP_OFF_TIM_COUNT)) begin
        count_q <= bus.wdata;
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign event_o = match;
  assign busy_o  = en_q;

  //**************************************************************************
  // bus response
  //**************************************************************************

  always_comb begin
    case (off)
      `CP_OFF_TIM_CFG:   rdata = word_t'(en_q);
      `CP_OFF_TIM_COUNT: rdata = count_q;
      `CP_OFF_TIM_CMP:   rdata = cmp_q;
      default:           rdata = `CP_ERR_RDATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rdata;
      r_id_q    <= bus.id;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_id    = r_id_q;

endmodule

// File: design/cluster_ctrl_unit.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module cluster_ctrl_unit
  import cluster_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  periph_bus_if.slave bus,
  input  logic        en_sa_boot_i,
  input  logic        fetch_en_i,
  output logic        eoc_o,
  output core_vec_t   fetch_enable_o,
  output word_t       boot_addr_o
);

  reg_off_t  off;
  logic      wr;
  logic      eoc_q;
  core_vec_t fetch_en_q;
  word_t     boot_addr_q;
  word_t     rdata;
  logic      r_valid_q;
  word_t     r_rdata_q;
  per_id_t   r_id_q;

  assign off     = bus.add[`CP_OFF_LSB +: 4];
  assign wr      = bus.req && !bus.wen;
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= en_sa_boot_i ? `CP_BOOT_ADDR : `CP_ROM_BOOT_ADDR;
    end else if (wr) begin
      case (off)
        `CP_OFF_EOC:       eoc_q       <= bus.wdata[0];
        `CP_OFF_FETCH_EN:  fetch_en_q  <= bus.wdata[`CP_NB_CORES-1:0];
        `CP_OFF_BOOT_ADDR: boot_addr_q <= bus.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (off)
      `CP_OFF_EOC:       rdata = word_t'(eoc_q);
      `CP_OFF_FETCH_EN:  rdata = word_t'(fetch_en_q);
      `CP_OFF_BOOT_ADDR: rdata = boot_addr_q;
      default:           rdata = `CP_ERR_RDATA;
    endcase
  end

  // response one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      r_rdata_q <= rdata;
      r_id_q    <= bus.id;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = r_rdata_q;
  assign bus.r_id    = r_id_q;

  // external fetch enable starts every core
  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q | {`CP_NB_CORES{fetch_en_i}};
  assign boot_addr_o    = boot_addr_q;

endmodule

// File: design/periph_demux.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module periph_demux
  import cluster_periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         req_i,
  input  word_t        add_i,
  input  logic         wen_i,
  input  word_t        wdata_i,
  input  per_id_t      id_i,
  output logic         gnt_o,
  output logic         r_valid_o,
  output word_t        r_rdata_o,
  output per_id_t      r_id_o,
  periph_bus_if.master ctrl_bus,
  periph_bus_if.master timer_bus,
  periph_bus_if.master eu_bus
);

  slot_t   req_slot;
  logic    accept;
  slot_t   rsp_slot_q;
  logic    rsp_pend_q;
  per_id_t rsp_id_q;

  assign req_slot = add_i[`CP_SLOT_LSB +: 2];
  assign accept   = req_i && gnt_o;

  // req goes to the selected slave only, the rest is broadcast
  assign ctrl_bus.req    = req_i && (req_slot == `CP_SLOT_CTRL);
  assign ctrl_bus.add    = add_i;
  assign ctrl_bus.wen    = wen_i;
  assign ctrl_bus.wdata  = wdata_i;
  assign ctrl_bus.id     = id_i;

  assign timer_bus.req   = req_i && (req_slot == `CP_SLOT_TIMER);
  assign timer_bus.add   = add_i;
  assign timer_bus.wen   = wen_i;
  assign timer_bus.wdata = wdata_i;
  assign timer_bus.id    = id_i;

  assign eu_bus.req      = req_i && (req_slot == `CP_SLOT_EU);
  assign eu_bus.add      = add_i;
  assign eu_bus.wen      = wen_i;
  assign eu_bus.wdata    = wdata_i;
  assign eu_bus.id       = id_i;

  // unmapped slot grants by itself
  always_comb begin
    case (req_slot)
      `CP_SLOT_CTRL:  gnt_o = ctrl_bus.gnt;
      `CP_SLOT_TIMER: gnt_o = timer_bus.gnt;
      `CP_SLOT_EU:    gnt_o = eu_bus.gnt;
      default:        gnt_o = req_i;
    endcase
  end

  // remember where the response comes from
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_pend_q <= 1'b0;
      rsp_slot_q <= `CP_SLOT_CTRL;
    end else begin
      rsp_pend_q <= accept;
      if (accept) begin
        rsp_slot_q <= req_slot;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_q <= id_i;
    end
  end

  always_comb begin
    case (rsp_slot_q)
      `CP_SLOT_CTRL: begin
        r_valid_o = ctrl_bus.r_valid;
        r_rdata_o = ctrl_bus.r_rdata;
        r_id_o    = ctrl_bus.r_id;
      end
      `CP_SLOT_TIMER: begin
        r_valid_o = timer_bus.r_valid;
        r_rdata_o = timer_bus.r_rdata;
        r_id_o    = timer_bus.r_id;
      end
      `CP_SLOT_EU: begin
        r_valid_o = eu_bus.r_valid;
        r_rdata_o = eu_bus.r_rdata;
        r_id_o    = eu_bus.r_id;
      end
      default: begin
        // error response for slot 3
        r_valid_o = rsp_pend_q;
        r_rdata_o = `CP_ERR_RDATA;
        r_id_o    = rsp_id_q;
      end
    endcase
  end

endmodule

// File: design/evt_ctrl_if.sv
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

interface evt_ctrl_if
  import cluster_periph_pkg::*;
();

  // per-core controls from the register block
  evt_t [`CP_NB_CORES-1:0] mask;
  evt_t [`CP_NB_CORES-1:0] buf_clr;
  logic                    sw_evt_valid;
  evt_t                    sw_evt;
  core_vec_t               sleep_set;

  // event buffers back from the core
  evt_t [`CP_NB_CORES-1:0] buffer;

  modport regs (
    output mask, buf_clr, sw_evt_valid, sw_evt, sleep_set,
    input  buffer
  );

  modport core (
    input  mask, buf_clr, sw_evt_valid, sw_evt, sleep_set,
    output buffer
  );

endinterface

// File: design/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if
  import cluster_periph_pkg::*;
();

  // request channel
  logic    req;
  word_t   add;
  logic    wen;
  word_t   wdata;
  per_id_t id;

  // response channel, r_valid one cycle after gnt
  logic    gnt;
  logic    r_valid;
  word_t   r_rdata;
  per_id_t r_id;

  modport master (
    output req, add, wen, wdata, id,
    input  gnt, r_valid, r_rdata, r_id
  );

  modport slave (
    input  req, add, wen, wdata, id,
    output gnt, r_valid, r_rdata, r_id
  );

endinterface

// File: design/cluster_periph_pkg.sv
`include "cluster_periph_defines.svh"

package cluster_periph_pkg;

  // data or address word
  typedef logic [31:0] word_t;

  // one bit per core
  typedef logic [`CP_NB_CORES-1:0] core_vec_t;

  // event lines of one core, timer on bit 0
  typedef logic [`CP_EVNT_WIDTH-1:0] evt_t;

  // one-hot requester id, bit c is core c
  typedef logic [`CP_NB_CORES:0] per_id_t;

  // slot code and register word offset
  typedef logic [1:0] slot_t;
  typedef logic [3:0] reg_off_t;

endpackage

// File: design/cluster_periph_defines.svh
`ifndef CLUSTER_PERIPH_DEFINES_SVH
`define CLUSTER_PERIPH_DEFINES_SVH

// cluster size and event lines per core
`define CP_NB_CORES      4
`define CP_EVNT_WIDTH    8

// boot address after reset, selected by en_sa_boot_i
`define CP_BOOT_ADDR     32'h1C00_0000
`define CP_ROM_BOOT_ADDR 32'h1A00_0000

// slot select, two address bits from here up
`define CP_SLOT_LSB      10
`define CP_SLOT_CTRL     2'd0
`define CP_SLOT_TIMER    2'd1
`define CP_SLOT_EU       2'd2

// word offset inside a slot, four address bits
`define CP_OFF_LSB       2

// control unit registers
`define CP_OFF_EOC       4'd0
`define CP_OFF_FETCH_EN  4'd1
`define CP_OFF_BOOT_ADDR 4'd2

// timer registers
`define CP_OFF_TIM_CFG   4'd0
`define CP_OFF_TIM_COUNT 4'd1
`define CP_OFF_TIM_CMP   4'd2

// event unit registers
`define CP_OFF_EU_MASK   4'd0
`define CP_OFF_EU_BUFFER 4'd1
`define CP_OFF_EU_SW_EVT 4'd2
`define CP_OFF_EU_SLEEP  4'd3

// read data for unmapped slot and offsets
`define CP_ERR_RDATA     32'hBADACCE5

`endif
